// ==== src/rvCorePkg.sv ====
package rvCorePkg;

    localparam int XLEN = 32;

    // Major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100  // Only ECALL is recognised
    } OpCode;

    typedef logic [4:0] RegAddr;

    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
        OpCode      opCode;
        logic [1:0] lowBits;  // Always 2'b11 for 32-bit encodings
    } Instruction;

    typedef enum logic [2:0] {
        ADD, SUB, COMP, XOR, LSHFT, RSHFT, OR, AND
    } AluCtrl;

    typedef struct packed {
        AluCtrl ctrl;
        logic   modifier;  // Unsigned compare or arithmetic right shift
    } DecodedAluCmd;

    typedef enum logic [1:0] {
        BITS8  = 2'b00,
        BITS16 = 2'b01,
        BITS32 = 2'b10,
        ERRVAL = 2'b11
    } AccessWidth;

    typedef struct packed {
        logic [XLEN-1:0] imm;  // Sign-extended, format picked by opcode
        logic            loadSigned;
        AccessWidth      width;
        logic            storeFunct3Err;
        logic            illegalOp;
    } WiredDecisions;

    typedef struct packed {
        logic [XLEN-1:0] addr;
    } FetchReq;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            write;
        logic [3:0]      byteEn;
        logic [XLEN-1:0] wdata;
    } DataReq;

endpackage

// ==== src/instrDecoder.sv ====
module instrDecoder (
    input  rvCorePkg::Instruction    instr,
    output rvCorePkg::OpCode         opCode,
    output rvCorePkg::DecodedAluCmd  aluCmd,
    output rvCorePkg::WiredDecisions decoded
);

    logic [rvCorePkg::XLEN-1:0] immI;
    logic [rvCorePkg::XLEN-1:0] immS;
    logic [rvCorePkg::XLEN-1:0] immB;
    logic [rvCorePkg::XLEN-1:0] immU;
    logic [rvCorePkg::XLEN-1:0] immJ;

    assign opCode = instr.opCode;

    assign immI = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2};
    assign immS = {{20{instr.funct7[6]}}, instr.funct7, instr.rd};
    assign immB = {{20{instr.funct7[6]}}, instr.rd[0], instr.funct7[5:0], instr.rd[4:1], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        aluCmd.ctrl     = rvCorePkg::ADD;  // Address and link arithmetic
        aluCmd.modifier = 1'b0;
        if (instr.opCode == rvCorePkg::OP || instr.opCode == rvCorePkg::OP_IMM) begin
            case (instr.funct3)
                3'b000: aluCmd.ctrl = (instr.opCode == rvCorePkg::OP && instr.funct7[5]) ?
                                      rvCorePkg::SUB : rvCorePkg::ADD;
                3'b001: aluCmd.ctrl = rvCorePkg::LSHFT;
                3'b010: aluCmd.ctrl = rvCorePkg::COMP;
                3'b011: begin
                    aluCmd.ctrl     = rvCorePkg::COMP;
                    aluCmd.modifier = 1'b1;  // SLTU
                end
                3'b100: aluCmd.ctrl = rvCorePkg::XOR;
                3'b101: begin
                    aluCmd.ctrl     = rvCorePkg::RSHFT;
                    aluCmd.modifier = instr.funct7[5];  // SRA
                end
                3'b110: aluCmd.ctrl = rvCorePkg::OR;
                default: aluCmd.ctrl = rvCorePkg::AND;
            endcase
        end else if (instr.opCode == rvCorePkg::BRANCH) begin
            // BEQ/BNE test the difference, the rest compare
            aluCmd.ctrl     = instr.funct3[2] ? rvCorePkg::COMP : rvCorePkg::SUB;
            aluCmd.modifier = instr.funct3[1];
        end
    end

    always_comb begin
        decoded.loadSigned     = !instr.funct3[2];
        decoded.width          = rvCorePkg::AccessWidth'(instr.funct3[1:0]);
        decoded.storeFunct3Err = instr.opCode == rvCorePkg::STORE && instr.funct3[2];
        decoded.illegalOp      = 1'b0;
        case (instr.opCode)
            rvCorePkg::LOAD, rvCorePkg::OP_IMM, rvCorePkg::JALR: decoded.imm = immI;
            rvCorePkg::STORE:                     decoded.imm = immS;
            rvCorePkg::BRANCH:                    decoded.imm = immB;
            rvCorePkg::LUI, rvCorePkg::AUIPC:     decoded.imm = immU;
            rvCorePkg::JAL:                       decoded.imm = immJ;
            rvCorePkg::OP, rvCorePkg::SYSTEM:     decoded.imm = '0;
            default: begin
                decoded.imm       = '0;
                decoded.illegalOp = 1'b1;  // Unknown major opcode
            end
        endcase
    end

endmodule

// ==== src/aluUnit.sv ====
module aluUnit (
    input  logic [rvCorePkg::XLEN-1:0] a,
    input  logic [rvCorePkg::XLEN-1:0] b,
    input  rvCorePkg::DecodedAluCmd    cmd,
    output logic [rvCorePkg::XLEN-1:0] result,
    output logic                       zero
);

    logic [$clog2(rvCorePkg::XLEN)-1:0] shamt;
    logic [rvCorePkg::XLEN-1:0]         sraResult;
    logic                               lessThan;

    assign shamt     = b[$clog2(rvCorePkg::XLEN)-1:0];
    assign sraResult = $signed(a) >>> shamt;  // Sign-filled right shift
    assign lessThan  = cmd.modifier ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (cmd.ctrl)
            rvCorePkg::ADD:   result = a + b;
            rvCorePkg::SUB:   result = a - b;
            rvCorePkg::COMP:  result = {{(rvCorePkg::XLEN-1){1'b0}}, lessThan};
            rvCorePkg::XOR:   result = a ^ b;
            rvCorePkg::LSHFT: result = a << shamt;
            rvCorePkg::RSHFT: result = cmd.modifier ? sraResult : a >> shamt;
            rvCorePkg::OR:    result = a | b;
            default:          result = a & b;
        endcase
    end

    assign zero = result == '0;  // Equality for BEQ/BNE

endmodule

// ==== src/regFile.sv ====
module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  rvCorePkg::RegAddr          rs1,
    input  rvCorePkg::RegAddr          rs2,
    input  rvCorePkg::RegAddr          rd,
    input  logic                       we,
    input  logic [rvCorePkg::XLEN-1:0] wdata,
    output logic [rvCorePkg::XLEN-1:0] rdata1,
    output logic [rvCorePkg::XLEN-1:0] rdata2
);

    logic [rvCorePkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// ==== src/reqAckRequester.sv ====
module reqAckRequester #(
    parameter type ReqT = rvCorePkg::FetchReq
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       start,
    input  ReqT                        payloadIn,
    output logic                       req,
    output ReqT                        payload,
    input  logic                       ack,
    input  logic [rvCorePkg::XLEN-1:0] rdata,
    output logic                       done,
    output logic [rvCorePkg::XLEN-1:0] rdataOut,
    output logic                       busy
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE  // req dropped, waiting for ack to fall
    } State;

    State state;
    logic pending;  // Start seen while still busy

    assign req  = state == REQ;
    assign busy = state != IDLE;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= IDLE;
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= req && ack;
            if (start && busy) begin
                pending <= 1'b1;
            end
            case (state)
                IDLE: if (start) state <= REQ;
                REQ:  if (ack) state <= RELEASE;
                default: if (!ack) begin
                    state   <= (pending || start) ? REQ : IDLE;
                    pending <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            payload <= payloadIn;  // Stable for the whole handshake
        end
        if (req && ack) begin
            rdataOut <= rdata;
        end
    end

endmodule

// ==== src/loadStoreUnit.sv ====
module loadStoreUnit (
    input  logic [1:0]                 addrLow,
    input  rvCorePkg::AccessWidth      width,
    input  logic                       loadSigned,
    input  logic [rvCorePkg::XLEN-1:0] storeData,
    input  logic [rvCorePkg::XLEN-1:0] memRdata,
    output logic [3:0]                 byteEnable,
    output logic [rvCorePkg::XLEN-1:0] alignedWdata,
    output logic [rvCorePkg::XLEN-1:0] loadResult
);

    logic [4:0]                 shiftAmt;
    logic [rvCorePkg::XLEN-1:0] laneData;

    assign shiftAmt     = {addrLow, 3'b000};
    assign alignedWdata = storeData << shiftAmt;  // Move into addressed lanes
    assign laneData     = memRdata >> shiftAmt;   // Addressed lanes down to bit 0

    always_comb begin
        case (width)
            rvCorePkg::BITS8: begin
                byteEnable = 4'b0001 << addrLow;
                loadResult = {{(rvCorePkg::XLEN-8){loadSigned & laneData[7]}}, laneData[7:0]};
            end
            rvCorePkg::BITS16: begin
                byteEnable = 4'b0011 << addrLow;
                loadResult = {{(rvCorePkg::XLEN-16){loadSigned & laneData[15]}},
                              laneData[15:0]};
            end
            default: begin
                byteEnable = 4'b1111;
                loadResult = memRdata;
            end
        endcase
    end

endmodule

// ==== src/coreControl.sv ====
module coreControl #(
    parameter logic [rvCorePkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  rvCorePkg::OpCode           opCode,
    input  rvCorePkg::WiredDecisions   decoded,
    input  logic [rvCorePkg::XLEN-1:0] aluResult,
    input  logic                       aluZero,
    input  logic [rvCorePkg::XLEN-1:0] rs1Data,
    input  logic [rvCorePkg::XLEN-1:0] rs2Data,
    output logic                       fetchStart,
    output rvCorePkg::FetchReq         fetchAddr,
    input  logic                       fetchDone,
    input  logic [rvCorePkg::XLEN-1:0] fetchData,
    output rvCorePkg::Instruction      instr,
    output logic                       dataStart,
    output rvCorePkg::DataReq          dataPayload,
    input  logic                       dataDone,
    input  logic [rvCorePkg::XLEN-1:0] loadResult,
    input  logic [3:0]                 byteEnable,
    input  logic [rvCorePkg::XLEN-1:0] alignedWdata,
    output logic [rvCorePkg::XLEN-1:0] aluA,
    output logic [rvCorePkg::XLEN-1:0] aluB,
    output logic                       regWe,
    output logic [rvCorePkg::XLEN-1:0] regWdata,
    output logic                       halted,
    output logic                       illegal
);

    typedef enum logic [2:0] {
        FETCH, EXECUTE, MEM, WRITEBACK, HALT
    } State;

    State                       state;
    logic [rvCorePkg::XLEN-1:0] pc;
    logic [rvCorePkg::XLEN-1:0] pcPlus4;
    logic [rvCorePkg::XLEN-1:0] nextPc;
    logic                       issued;  // Start already sent for this access
    logic                       cond;
    logic                       taken;
    logic                       writesRd;
    logic                       stop;

    assign pcPlus4    = pc + 4;
    assign fetchStart = state == FETCH && !issued;
    assign dataStart  = state == MEM && !issued;
    assign fetchAddr  = '{addr: pc};
    assign halted     = state == HALT;

    // Operands stay stable from EXECUTE until the PC moves in WRITEBACK
    assign aluA = (opCode == rvCorePkg::AUIPC || opCode == rvCorePkg::JAL) ? pc : rs1Data;
    assign aluB = (opCode == rvCorePkg::OP || opCode == rvCorePkg::BRANCH) ? rs2Data : decoded.imm;

    assign dataPayload = '{addr: aluResult, write: opCode == rvCorePkg::STORE,
                           byteEn: byteEnable, wdata: alignedWdata};

    assign writesRd = !(opCode inside {rvCorePkg::STORE, rvCorePkg::BRANCH, rvCorePkg::SYSTEM});
    assign regWe    = state == WRITEBACK && writesRd;
    assign stop     = opCode == rvCorePkg::SYSTEM || decoded.illegalOp || decoded.storeFunct3Err;

    always_comb begin
        case (instr.funct3[2:1])
            2'b00:   cond = aluZero;        // BEQ/BNE
            2'b01:   cond = 1'b0;
            default: cond = aluResult[0];   // Less-than from COMP
        endcase
    end

    assign taken = cond ^ instr.funct3[0];  // Odd funct3 inverts the test

    always_comb begin
        nextPc   = pcPlus4;
        regWdata = aluResult;
        case (opCode)
            rvCorePkg::LUI:  regWdata = decoded.imm;
            rvCorePkg::LOAD: regWdata = loadResult;
            rvCorePkg::JAL: begin
                regWdata = pcPlus4;
                nextPc   = aluResult;
            end
            rvCorePkg::JALR: begin
                regWdata = pcPlus4;
                nextPc   = {aluResult[rvCorePkg::XLEN-1:1], 1'b0};
            end
            rvCorePkg::BRANCH: nextPc = taken ? pc + decoded.imm : pcPlus4;
            default: nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= FETCH;
            pc      <= RESET_PC;
            issued  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            if (fetchStart || dataStart) begin
                issued <= 1'b1;
            end
            case (state)
                FETCH: if (fetchDone) begin
                    state  <= EXECUTE;
                    issued <= 1'b0;
                end
                EXECUTE: begin
                    if (stop) begin
                        state   <= HALT;
                        illegal <= decoded.illegalOp || decoded.storeFunct3Err;
                    end else if (opCode == rvCorePkg::LOAD || opCode == rvCorePkg::STORE) begin
                        state <= MEM;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEM: if (dataDone) begin
                    state  <= WRITEBACK;
                    issued <= 1'b0;
                end
                WRITEBACK: begin
                    pc    <= nextPc;
                    state <= FETCH;
                end
                default: state <= HALT;  // Held until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instr <= fetchData;
        end
    end

endmodule

// ==== src/rvCore.sv ====
module rvCore #(
    parameter logic [rvCorePkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rstN,
    output logic                       fetchReq,
    output rvCorePkg::FetchReq         fetchPayload,
    input  logic                       fetchAck,
    input  logic [rvCorePkg::XLEN-1:0] fetchData,
    output logic                       dataReq,
    output rvCorePkg::DataReq          dataPayload,
    input  logic                       dataAck,
    input  logic [rvCorePkg::XLEN-1:0] dataRdata,
    output logic                       halted,
    output logic                       illegal
);

    rvCorePkg::OpCode           opCode;
    rvCorePkg::WiredDecisions   decoded;
    rvCorePkg::DecodedAluCmd    aluCmd;
    rvCorePkg::Instruction      instr;
    rvCorePkg::FetchReq         fetchAddr;
    rvCorePkg::DataReq          dataReqIn;
    logic [rvCorePkg::XLEN-1:0] aluA, aluB, aluResult, rs1Data, rs2Data, regWdata;
    logic [rvCorePkg::XLEN-1:0] fetchWord, dataWord, loadResult, alignedWdata;
    logic [3:0]                 byteEnable;
    logic                       aluZero, regWe, fetchStart, fetchDone, dataStart, dataDone;

    coreControl #(.RESET_PC(RESET_PC)) u_coreControl (
        .clk, .rstN, .opCode, .decoded, .aluResult, .aluZero, .rs1Data, .rs2Data,
        .fetchStart, .fetchAddr, .fetchDone, .fetchData(fetchWord), .instr,
        .dataStart, .dataPayload(dataReqIn), .dataDone, .loadResult, .byteEnable,
        .alignedWdata, .aluA, .aluB, .regWe, .regWdata, .halted, .illegal
    );

    instrDecoder u_instrDecoder (.instr, .opCode, .aluCmd, .decoded);

    aluUnit u_aluUnit (.a(aluA), .b(aluB), .cmd(aluCmd), .result(aluResult), .zero(aluZero));

    regFile u_regFile (
        .clk, .rstN, .rs1(instr.rs1), .rs2(instr.rs2), .rd(instr.rd),
        .we(regWe), .wdata(regWdata), .rdata1(rs1Data), .rdata2(rs2Data)
    );

    loadStoreUnit u_loadStoreUnit (
        .addrLow(aluResult[1:0]), .width(decoded.width), .loadSigned(decoded.loadSigned),
        .storeData(rs2Data), .memRdata(dataWord), .byteEnable, .alignedWdata, .loadResult
    );

    reqAckRequester #(.ReqT(rvCorePkg::FetchReq)) u_fetchRequester (
        .clk, .rstN, .start(fetchStart), .payloadIn(fetchAddr), .req(fetchReq),
        .payload(fetchPayload), .ack(fetchAck), .rdata(fetchData), .done(fetchDone),
        .rdataOut(fetchWord), .busy()
    );

    reqAckRequester #(.ReqT(rvCorePkg::DataReq)) u_dataRequester (
        .clk, .rstN, .start(dataStart), .payloadIn(dataReqIn), .req(dataReq),
        .payload(dataPayload), .ack(dataAck), .rdata(dataRdata), .done(dataDone),
        .rdataOut(dataWord), .busy()
    );

endmodule

// ==== verification/memModel.sv ====
module memModel (
    input  logic               clk,
    input  logic               fetchReq,
    input  rvCorePkg::FetchReq fetchPayload,
    output logic               fetchAck,
    output logic [31:0]        fetchData,
    input  logic               dataReq,
    input  rvCorePkg::DataReq  dataPayload,
    output logic               dataAck,
    output logic [31:0]        dataRdata,
    output logic [31:0]        storeAddr,
    output logic [3:0]         storeBe,
    output logic [31:0]        storeData,
    output int                 storeCount,
    output logic               hangErr
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [256];  // Word array, byte address bits 9:2

    initial begin
        fetchAck   = 1'b0;
        fetchData  = '0;
        dataAck    = 1'b0;
        dataRdata  = '0;
        storeAddr  = '0;
        storeBe    = '0;
        storeData  = '0;
        storeCount = 0;
        hangErr    = 1'b0;
    end

    task automatic clearMem();
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) * 32'h01F3_1A27) ^ 32'hA5A5_0000;  // Whole-address pattern
        end
        storeCount = 0;
        hangErr    = 1'b0;
    endtask

    task automatic loadWord(input int idx, input logic [31:0] word);
        mem[idx] = word;
    endtask

    always begin : fetchSlave
        int delay;
        int t;
        @(negedge clk);
        if (fetchReq) begin
            delay = $urandom % 6;
            repeat (delay) @(negedge clk);
            fetchData = mem[fetchPayload.addr[9:2]];
            fetchAck  = 1'b1;
            for (t = 0; fetchReq && t < 1000; t++) @(negedge clk);
            if (fetchReq) hangErr = 1'b1;  // Requester never released
            fetchAck = 1'b0;
        end
    end

    always begin : dataSlave
        int delay;
        int t;
        @(negedge clk);
        if (dataReq) begin
            delay = $urandom % 6;
            repeat (delay) @(negedge clk);
            if (dataPayload.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (dataPayload.byteEn[b])
                        mem[dataPayload.addr[9:2]][8*b +: 8] = dataPayload.wdata[8*b +: 8];
                end
                storeAddr  = dataPayload.addr;
                storeBe    = dataPayload.byteEn;
                storeData  = dataPayload.wdata;
                storeCount = storeCount + 1;
            end
            dataRdata = mem[dataPayload.addr[9:2]];
            dataAck   = 1'b1;
            for (t = 0; dataReq && t < 1000; t++) @(negedge clk);
            if (dataReq) hangErr = 1'b1;
            dataAck = 1'b0;
        end
    end

endmodule

// ==== verification/rvCoreTb.sv ====
module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] LOAD = 7'h03, STORE = 7'h23, OPIMM = 7'h13, OP = 7'h33;
    localparam logic [6:0] LUI = 7'h37, AUIPC = 7'h17, JALR = 7'h67;
    localparam logic [31:0] ECALL = 32'h0000_0073;
    localparam int MAX_ENTRIES = 24;

    logic clk, rstN, fetchReq, fetchAck, dataReq, dataAck, halted, illegal, hangErr;
    logic [31:0] fetchData, dataRdata, storeAddr, storeData;
    logic [3:0] storeBe;
    int storeCount;
    rvCorePkg::FetchReq fetchPayload;
    rvCorePkg::DataReq dataPayload;

    logic [31:0] progTable [MAX_ENTRIES][8];
    string       nameTable [MAX_ENTRIES];
    logic [31:0] addrTable [MAX_ENTRIES];
    logic [3:0]  beTable   [MAX_ENTRIES];
    logic [31:0] dataTable [MAX_ENTRIES];
    logic        illTable  [MAX_ENTRIES];
    logic [31:0] stage [$];  // Program being assembled
    int nEntries = 0;

    rvCore u_rvCore (.*);
    memModel u_memModel (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] encI(logic [6:0] op, int rd, int f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
    endfunction

    function automatic logic [31:0] encS(int f3, int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encB(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(logic [6:0] op, int rd, int imm20);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encJ(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    task automatic emitWords(input logic [31:0] words [$]);
        foreach (words[i]) stage.push_back(words[i]);
    endtask

    // Commits the staged program, padded with ECALL
    task automatic addEntry(string nm, logic [31:0] addr, logic [3:0] be, logic [31:0] data,
                            logic ill);
        for (int i = 0; i < 8; i++) progTable[nEntries][i] = (i < stage.size()) ? stage[i] : ECALL;
        nameTable[nEntries] = nm;
        addrTable[nEntries] = addr;
        beTable[nEntries]   = be;
        dataTable[nEntries] = data;
        illTable[nEntries]  = ill;
        nEntries++;
        stage.delete();
    endtask

    // First branch must fall through, second must be taken, leaving k in x6
    task automatic branchPair(string nm, int f3a, int ra, int rb, int f3b, int rc, int rd, int k);
        emitWords('{encI(OPIMM, 1, 0, 0, -5), encI(OPIMM, 2, 0, 0, 3), encB(f3a, ra, rb, 8),
                    encB(f3b, rc, rd, 8), encI(OPIMM, 6, 0, 0, 'h11), encI(OPIMM, 6, 0, 6, k),
                    encS(2, 6, 0, 'h100)});
        addEntry(nm, 32'h100, 4'hF, 32'(k), 1'b0);
    endtask

    task automatic subStore(int f3, int off, logic [3:0] be, logic [31:0] data);
        emitWords('{encU(LUI, 1, 'h87654), encI(OPIMM, 1, 0, 1, 'h321),
                    encS(f3, 1, 0, 'h100 + off)});
        addEntry($sformatf("%s%0d", f3 == 0 ? "sb" : "sh", off), 32'('h100 + off), be, data,
                 1'b0);
    endtask

    // Word 8090A0B0 makes every byte and half negative
    task automatic subLoad(int f3, int off, logic [31:0] exp);
        emitWords('{encU(LUI, 1, 'h8090A), encI(OPIMM, 1, 0, 1, 'h0B0), encS(2, 1, 0, 'h100),
                    encI(LOAD, 2, f3, 0, 'h100 + off), encS(2, 2, 0, 'h104)});
        addEntry($sformatf("load f3=%0d off=%0d", f3, off), 32'h104, 4'hF, exp, 1'b0);
    endtask

    task automatic buildTable();
        emitWords('{encI(OPIMM, 1, 0, 0, 100), encI(OPIMM, 2, 0, 0, -30), encR('h20, 2, 1, 0, 3),
                    encR(0, 1, 3, 0, 3), encS(2, 3, 0, 'h100)});
        addEntry("addSub", 32'h100, 4'hF, 32'd230, 1'b0);
        emitWords('{encI(OPIMM, 1, 0, 0, 'h5A3), encI(OPIMM, 2, 0, 0, 'h0FF), encR(0, 2, 1, 4, 3),
                    encR(0, 1, 3, 6, 4), encR(0, 2, 4, 7, 5), encR(0, 3, 5, 0, 6),
                    encS(2, 6, 0, 'h100)});
        addEntry("xorOrAnd", 32'h100, 4'hF, 32'h65B, 1'b0);
        emitWords('{encI(OPIMM, 1, 0, 0, -1), encI(OPIMM, 2, 0, 0, 1), encR(0, 2, 1, 2, 3),
                    encR(0, 2, 1, 3, 4), encI(OPIMM, 3, 1, 3, 4), encR(0, 4, 3, 6, 5),
                    encS(2, 5, 0, 'h100)});
        addEntry("sltSltu", 32'h100, 4'hF, 32'h10, 1'b0);
        emitWords('{encI(OPIMM, 1, 0, 0, -256), encI(OPIMM, 2, 0, 0, 4), encR('h20, 2, 1, 5, 3),
                    encR(0, 2, 3, 5, 4), encR(0, 2, 4, 1, 5), encS(2, 5, 0, 'h100)});
        addEntry("shiftReg", 32'h100, 4'hF, 32'hFFFF_FFF0, 1'b0);
        emitWords('{encI(OPIMM, 1, 0, 0, -2048), encI(OPIMM, 2, 5, 1, 'h408),
                    encI(OPIMM, 3, 5, 2, 28), encI(OPIMM, 4, 1, 3, 20), encR(0, 2, 4, 0, 5),
                    encS(2, 5, 0, 'h100)});
        addEntry("shiftImm", 32'h100, 4'hF, 32'h00EF_FFF8, 1'b0);
        emitWords('{encU(LUI, 1, 'h12345), encU(AUIPC, 2, 1), encR(0, 2, 1, 0, 3),
                    encS(2, 3, 0, 'h100)});
        addEntry("luiAuipc", 32'h100, 4'hF, 32'h1234_6004, 1'b0);
        // JAL to 20, JALR back to 8 with the low target bit cleared
        emitWords('{encJ(1, 20), encI(OPIMM, 3, 0, 0, 77), encR(0, 2, 1, 0, 4),
                    encS(2, 4, 0, 'h100), ECALL, encI(JALR, 2, 0, 1, 5)});
        addEntry("jalJalr", 32'h100, 4'hF, 32'd28, 1'b0);
        branchPair("beqNotBltTaken", 0, 1, 2, 4, 1, 2, 'h22);
        branchPair("bneNotBgeuTaken", 1, 1, 1, 7, 1, 2, 'h44);
        branchPair("bltNotBneTaken", 4, 2, 1, 1, 1, 2, 'h55);
        branchPair("bgeuNotBeqTaken", 7, 2, 1, 0, 1, 1, 'h66);
        subStore(0, 0, 4'b0001, 32'h0000_0021);
        subStore(0, 1, 4'b0010, 32'h0000_2100);
        subStore(0, 2, 4'b0100, 32'h0021_0000);
        subStore(0, 3, 4'b1000, 32'h2100_0000);
        subStore(1, 0, 4'b0011, 32'h0000_4321);
        subStore(1, 2, 4'b1100, 32'h4321_0000);
        subLoad(0, 1, 32'hFFFF_FFA0);
        subLoad(4, 3, 32'h0000_0080);
        subLoad(1, 2, 32'hFFFF_8090);
        subLoad(5, 0, 32'h0000_A0B0);
        emitWords('{encI(OPIMM, 1, 0, 0, 42), encS(2, 1, 0, 'h100), 32'hFFFF_FFFF});
        addEntry("illegalOp", 32'h100, 4'hF, 32'd42, 1'b1);
        emitWords('{encI(OPIMM, 1, 0, 0, 7), encS(2, 1, 0, 'h100), ECALL,
                    encI(OPIMM, 1, 0, 0, 9), encS(2, 1, 0, 'h100)});
        addEntry("ecallStop", 32'h100, 4'hF, 32'd7, 1'b0);
    endtask

    task automatic abortRun(string line);
        $display("Test failures found");
        $fatal(1, "%s", line);
    endtask

    initial begin
        int cycles;
        logic [31:0] mask;
        void'($urandom(31442));
        rstN = 1'b0;
        buildTable();
        for (int t = 0; t < nEntries; t++) begin
            @(negedge clk);
            rstN = 1'b0;
            u_memModel.clearMem();
            for (int i = 0; i < 8; i++) u_memModel.loadWord(i, progTable[t][i]);
            repeat (3) @(negedge clk);
            rstN = 1'b1;
            for (cycles = 0; !halted && !hangErr && cycles < 5000; cycles++) @(negedge clk);
            assert (!hangErr)
                else abortRun($sformatf("%s: memory handshake never completed", nameTable[t]));
            assert (halted)
                else abortRun($sformatf("%s: core did not halt in time", nameTable[t]));
            assert (storeCount > 0)
                else abortRun($sformatf("%s: no store reached memory", nameTable[t]));
            mask = {{8{beTable[t][3]}}, {8{beTable[t][2]}}, {8{beTable[t][1]}},
                    {8{beTable[t][0]}}};  // Only enabled lanes carry data
            assert (storeAddr == addrTable[t])
                else abortRun($sformatf("ERROR %s: expected addr %h, actual %h",
                                        nameTable[t], addrTable[t], storeAddr));
            assert (storeBe == beTable[t])
                else abortRun($sformatf("ERROR %s: expected byte enable %b, actual %b",
                                        nameTable[t], beTable[t], storeBe));
            assert ((storeData & mask) == (dataTable[t] & mask))
                else abortRun($sformatf("ERROR %s: expected data %h, actual %h", nameTable[t],
                                        dataTable[t] & mask, storeData & mask));
            assert (illegal == illTable[t])
                else abortRun($sformatf("ERROR %s: expected illegal %b, actual %b",
                                        nameTable[t], illTable[t], illegal));
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== src.f ====
src/rvCorePkg.sv
src/instrDecoder.sv
src/aluUnit.sv
src/regFile.sv
src/reqAckRequester.sv
src/loadStoreUnit.sv
src/coreControl.sv
src/rvCore.sv
verification/memModel.sv
verification/rvCoreTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = rvCoreTb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | grep "All tests passed!"

clean:
	rm -rf obj_dir
